//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tb_aes_periph
FILELIST  ?= verilog.f

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module aes_periph hdl/aes_pkg.sv \
		hdl/periph_ifs.sv hdl/axi_slave_port.sv hdl/aes_regs.sv \
		hdl/aes_cipher.sv hdl/aes_periph.sv

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

//--- hdl/aes_cipher.sv
`timescale 1ns/1ps
`default_nettype none

module aes_cipher import aes_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  cipher_if.core  cipher
);

  logic [BLOCK_WIDTH-1:0] state_q;
  logic [BLOCK_WIDTH-1:0] rk_q;
  logic [BLOCK_WIDTH-1:0] rk_next;
  logic [BLOCK_WIDTH-1:0] shifted;
  logic [BLOCK_WIDTH-1:0] mixed;
  logic [ROUND_BITS-1:0]  round_q;
  logic                   busy_q;
  logic                   done_q;
  logic                   start_ok;
  logic                   round_en;

  function automatic logic [127:0] sub_bytes(input logic [127:0] s);
    logic [127:0] r;
    for (int k = 0; k < 16; k++) begin
      r[8*k +: 8] = aes_sbox(s[8*k +: 8]);
    end
    return r;
  endfunction

  // Byte 4c+r sits at bits 127-8*(4c+r) down
  function automatic logic [127:0] shift_rows(input logic [127:0] s);
    logic [127:0] r;
    for (int c = 0; c < 4; c++) begin
      for (int row = 0; row < 4; row++) begin
        r[127 - 8*(4*c + row) -: 8] = s[127 - 8*(4*((c + row) % 4) + row) -: 8];
      end
    end
    return r;
  endfunction

  function automatic logic [7:0] xtime(input logic [7:0] b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  function automatic logic [31:0] mix_column(input logic [31:0] col);
    logic [7:0] a0;
    logic [7:0] a1;
    logic [7:0] a2;
    logic [7:0] a3;
    a0 = col[31:24];
    a1 = col[23:16];
    a2 = col[15:8];
    a3 = col[7:0];
    return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
            a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
            a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
            xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
  endfunction

  function automatic logic [127:0] mix_columns(input logic [127:0] s);
    logic [127:0] r;
    for (int c = 0; c < 4; c++) begin
      r[127 - 32*c -: 32] = mix_column(s[127 - 32*c -: 32]);
    end
    return r;
  endfunction

  function automatic logic [127:0] next_key(input logic [127:0] rk, input logic [7:0] rc);
    logic [31:0] w0;
    logic [31:0] w1;
    logic [31:0] w2;
    logic [31:0] w3;
    logic [31:0] t;
    w0 = rk[127:96];
    w1 = rk[95:64];
    w2 = rk[63:32];
    w3 = rk[31:0];
    // RotWord then SubWord
    t  = {aes_sbox(w3[23:16]), aes_sbox(w3[15:8]), aes_sbox(w3[7:0]), aes_sbox(w3[31:24])};
    w0 = w0 ^ t ^ {rc, 24'h000000};
    w1 = w1 ^ w0;
    w2 = w2 ^ w1;
    w3 = w3 ^ w2;
    return {w0, w1, w2, w3};
  endfunction

  assign start_ok = cipher.start && !busy_q;      // Start while busy is dropped
  assign round_en = busy_q && (round_q != NUM_ROUNDS);

  assign rk_next = next_key(rk_q, aes_rcon(round_q + 4'd1));
  assign shifted = shift_rows(sub_bytes(state_q));
  assign mixed   = (round_q == NUM_ROUNDS - 4'd1) ? shifted : mix_columns(shifted);

  assign cipher.busy   = busy_q;
  assign cipher.done   = done_q;
  assign cipher.result = state_q;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      busy_q  <= 1'b0;
      done_q  <= 1'b0;
      round_q <= '0;
    end else begin
      done_q <= 1'b0;
      if (start_ok) begin
        busy_q  <= 1'b1;
        round_q <= '0;
      end else if (round_en) begin
        round_q <= round_q + 4'd1;
      end else if (busy_q) begin
        busy_q <= 1'b0;   // All rounds applied
        done_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= '0;
    end else if (start_ok) begin
      state_q <= cipher.block ^ cipher.key;   // Initial AddRoundKey
    end else if (round_en) begin
      state_q <= mixed ^ rk_next;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_ok) begin
      rk_q <= cipher.key;
    end else if (round_en) begin
      rk_q <= rk_next;
    end
  end

  a_round_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    round_q <= NUM_ROUNDS);

endmodule

`default_nettype wire

//--- hdl/aes_periph.sv
`timescale 1ns/1ps
`default_nettype none

module aes_periph import aes_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // AW channel
  input  logic [ID_BITS-1:0]    awid_i,
  input  logic [ADDR_WIDTH-1:0] awaddr_i,
  input  logic [LEN_BITS-1:0]   awlen_i,
  input  logic [SIZE_BITS-1:0]  awsize_i,
  input  logic [1:0]            awburst_i,
  input  logic                  awvalid_i,
  output logic                  awready_o,
  // W channel
  input  logic [DATA_WIDTH-1:0] wdata_i,
  input  logic [STRB_WIDTH-1:0] wstrb_i,
  input  logic                  wvalid_i,
  input  logic                  wlast_i,
  output logic                  wready_o,
  // B channel
  output logic [ID_BITS-1:0]    bid_o,
  output logic [1:0]            bresp_o,
  output logic                  bvalid_o,
  input  logic                  bready_i,
  // AR channel
  input  logic [ID_BITS-1:0]    arid_i,
  input  logic [ADDR_WIDTH-1:0] araddr_i,
  input  logic [LEN_BITS-1:0]   arlen_i,
  input  logic [SIZE_BITS-1:0]  arsize_i,
  input  logic [1:0]            arburst_i,
  input  logic                  arvalid_i,
  output logic                  arready_o,
  // R channel
  output logic [ID_BITS-1:0]    rid_o,
  output logic [DATA_WIDTH-1:0] rdata_o,
  output logic [1:0]            rresp_o,
  output logic                  rvalid_o,
  output logic                  rlast_o,
  input  logic                  rready_i,
  // Interrupt
  output logic                  aes_irq_o,
  input  logic                  aes_clear_irq_i
);

  reg_bus_if reg_bus ();
  cipher_if  cipher_bus ();

  // AXI ports connect by name
  axi_slave_port i_axi_slave_port (
    .*,
    .bus (reg_bus)
  );

  aes_regs i_aes_regs (
    .clk_i,
    .rst_ni,
    .bus             (reg_bus),
    .cipher          (cipher_bus),
    .aes_irq_o,
    .aes_clear_irq_i
  );

  aes_cipher i_aes_cipher (
    .clk_i,
    .rst_ni,
    .cipher (cipher_bus)
  );

endmodule

`default_nettype wire

//--- hdl/aes_pkg.sv
`default_nettype none

package aes_pkg;

  // Bus widths
  localparam int ADDR_WIDTH    = 32;
  localparam int DATA_WIDTH    = 32;
  localparam int STRB_WIDTH    = DATA_WIDTH / 8;
  localparam int ID_BITS       = 4;
  localparam int LEN_BITS      = 8;
  localparam int SIZE_BITS     = 3;
  localparam int REG_ADDR_BITS = 6;   // Low address bits used for decode

  localparam int BLOCK_WIDTH = 128;
  localparam int BLOCK_WORDS = BLOCK_WIDTH / DATA_WIDTH;
  localparam int ROUND_BITS  = 4;

  // Register map, byte offsets
  localparam logic [REG_ADDR_BITS-1:0] CTRL_OFS   = 6'h00;
  localparam logic [REG_ADDR_BITS-1:0] STATUS_OFS = 6'h04;
  localparam logic [REG_ADDR_BITS-1:0] KEY_OFS    = 6'h10;
  localparam logic [REG_ADDR_BITS-1:0] DIN_OFS    = 6'h20;
  localparam logic [REG_ADDR_BITS-1:0] DOUT_OFS   = 6'h30;

  localparam logic [ROUND_BITS-1:0] NUM_ROUNDS = 4'd10;
  localparam logic [1:0]            RESP_OKAY  = 2'b00;

  // AXI port FSM states
  localparam int PORT_STATE_BITS = 3;
  localparam logic [PORT_STATE_BITS-1:0] ST_IDLE  = 3'd0;
  localparam logic [PORT_STATE_BITS-1:0] ST_WDATA = 3'd1;
  localparam logic [PORT_STATE_BITS-1:0] ST_WRESP = 3'd2;
  localparam logic [PORT_STATE_BITS-1:0] ST_READ  = 3'd3;
  localparam logic [PORT_STATE_BITS-1:0] ST_RRESP = 3'd4;

  // Forward S-box, one row of 16 bytes per upper nibble
  localparam logic [127:0] SBOX_ROWS [16] = '{
    128'h637c777bf26b6fc53001672bfed7ab76,
    128'hca82c97dfa5947f0add4a2af9ca472c0,
    128'hb7fd9326363ff7cc34a5e5f171d83115,
    128'h04c723c31896059a071280e2eb27b275,
    128'h09832c1a1b6e5aa0523bd6b329e32f84,
    128'h53d100ed20fcb15b6acbbe394a4c58cf,
    128'hd0efaafb434d338545f9027f503c9fa8,
    128'h51a3408f929d38f5bcb6da2110fff3d2,
    128'hcd0c13ec5f974417c4a77e3d645d1973,
    128'h60814fdc222a908846eeb814de5e0bdb,
    128'he0323a0a4906245cc2d3ac629195e479,
    128'he7c8376d8dd54ea96c56f4ea657aae08,
    128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
    128'h703eb5664803f60e613557b986c11d9e,
    128'he1f8981169d98e949b1e87e9ce5528df,
    128'h8ca1890dbfe6426841992d0fb054bb16
  };

  function automatic logic [7:0] aes_sbox(input logic [7:0] b);
    logic [127:0] row;
    row = SBOX_ROWS[b[7:4]];
    return row[127 - 8 * b[3:0] -: 8];
  endfunction

  // Round constant for rounds 1..10
  function automatic logic [7:0] aes_rcon(input logic [ROUND_BITS-1:0] round);
    case (round)
      4'd1:    return 8'h01;
      4'd2:    return 8'h02;
      4'd3:    return 8'h04;
      4'd4:    return 8'h08;
      4'd5:    return 8'h10;
      4'd6:    return 8'h20;
      4'd7:    return 8'h40;
      4'd8:    return 8'h80;
      4'd9:    return 8'h1b;
      4'd10:   return 8'h36;
      default: return 8'h00;
    endcase
  endfunction

endpackage

`default_nettype wire

//--- hdl/aes_regs.sv
`timescale 1ns/1ps
`default_nettype none

module aes_regs import aes_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  reg_bus_if.target  bus,
  cipher_if.ctrl     cipher,
  output logic       aes_irq_o,
  input  logic       aes_clear_irq_i
);

  logic [DATA_WIDTH-1:0] key_q [BLOCK_WORDS];
  logic [DATA_WIDTH-1:0] din_q [BLOCK_WORDS];
  logic [DATA_WIDTH-1:0] rdata_q;
  logic [DATA_WIDTH-1:0] rdata_d;
  logic                  done_flag_q;
  logic                  irq_q;
  logic [1:0]            wr_grp;
  logic [1:0]            wr_word;
  logic [1:0]            rd_grp;
  logic [1:0]            rd_word;

  assign wr_grp  = bus.waddr[REG_ADDR_BITS-1:4];
  assign wr_word = bus.waddr[3:2];
  assign rd_grp  = bus.raddr[REG_ADDR_BITS-1:4];
  assign rd_word = bus.raddr[3:2];

  // Word 0 carries the most significant bits
  assign cipher.key   = {key_q[0], key_q[1], key_q[2], key_q[3]};
  assign cipher.block = {din_q[0], din_q[1], din_q[2], din_q[3]};
  assign cipher.start = bus.we && (bus.waddr == CTRL_OFS) && bus.strb[0] && bus.wdata[0];

  assign bus.rdata = rdata_q;
  assign aes_irq_o = irq_q;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int i = 0; i < BLOCK_WORDS; i++) begin
        key_q[i] <= '0;
        din_q[i] <= '0;
      end
    end else if (bus.we) begin
      for (int b = 0; b < STRB_WIDTH; b++) begin
        if (bus.strb[b] && (wr_grp == KEY_OFS[REG_ADDR_BITS-1:4])) begin
          key_q[wr_word][8*b +: 8] <= bus.wdata[8*b +: 8];
        end
        if (bus.strb[b] && (wr_grp == DIN_OFS[REG_ADDR_BITS-1:4])) begin
          din_q[wr_word][8*b +: 8] <= bus.wdata[8*b +: 8];
        end
      end
    end
  end

  // Done flag follows the most recent start
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      done_flag_q <= 1'b0;
      irq_q       <= 1'b0;
    end else begin
      if (cipher.start) begin
        done_flag_q <= 1'b0;
      end else if (cipher.done) begin
        done_flag_q <= 1'b1;
      end
      if (cipher.done) begin
        irq_q <= 1'b1;       // Set beats clear
      end else if (aes_clear_irq_i) begin
        irq_q <= 1'b0;
      end
    end
  end

  always_comb begin
    rdata_d = '0;
    case (rd_grp)
      KEY_OFS[REG_ADDR_BITS-1:4]:  rdata_d = key_q[rd_word];
      DIN_OFS[REG_ADDR_BITS-1:4]:  rdata_d = din_q[rd_word];
      DOUT_OFS[REG_ADDR_BITS-1:4]: begin
        rdata_d = cipher.result[DATA_WIDTH*(BLOCK_WORDS-1-rd_word) +: DATA_WIDTH];
      end
      default: begin
        // CTRL reads as zero
        if (bus.raddr == STATUS_OFS) rdata_d = DATA_WIDTH'({done_flag_q, cipher.busy});
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (bus.re) begin
      rdata_q <= rdata_d;
    end
  end

  a_done_after_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cipher.done |-> $past(cipher.busy));

endmodule

`default_nettype wire

//--- hdl/axi_slave_port.sv
`timescale 1ns/1ps
`default_nettype none

module axi_slave_port import aes_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // AW channel
  input  logic [ID_BITS-1:0]    awid_i,
  input  logic [ADDR_WIDTH-1:0] awaddr_i,
  input  logic [LEN_BITS-1:0]   awlen_i,
  input  logic [SIZE_BITS-1:0]  awsize_i,
  input  logic [1:0]            awburst_i,
  input  logic                  awvalid_i,
  output logic                  awready_o,
  // W channel
  input  logic [DATA_WIDTH-1:0] wdata_i,
  input  logic [STRB_WIDTH-1:0] wstrb_i,
  input  logic                  wvalid_i,
  input  logic                  wlast_i,
  output logic                  wready_o,
  // B channel
  output logic [ID_BITS-1:0]    bid_o,
  output logic [1:0]            bresp_o,
  output logic                  bvalid_o,
  input  logic                  bready_i,
  // AR channel
  input  logic [ID_BITS-1:0]    arid_i,
  input  logic [ADDR_WIDTH-1:0] araddr_i,
  input  logic [LEN_BITS-1:0]   arlen_i,
  input  logic [SIZE_BITS-1:0]  arsize_i,
  input  logic [1:0]            arburst_i,
  input  logic                  arvalid_i,
  output logic                  arready_o,
  // R channel
  output logic [ID_BITS-1:0]    rid_o,
  output logic [DATA_WIDTH-1:0] rdata_o,
  output logic [1:0]            rresp_o,
  output logic                  rvalid_o,
  output logic                  rlast_o,
  input  logic                  rready_i,
  reg_bus_if.slave              bus
);

  logic [PORT_STATE_BITS-1:0] state_q;
  logic [PORT_STATE_BITS-1:0] state_d;
  logic [ID_BITS-1:0]         id_q;     // One transaction at a time, so one ID register
  logic [REG_ADDR_BITS-1:0]   addr_q;
  logic                       aw_hs;
  logic                       ar_hs;

  assign awready_o = (state_q == ST_IDLE);
  assign arready_o = (state_q == ST_IDLE) && !awvalid_i;  // Write wins a tie
  assign wready_o  = (state_q == ST_WDATA);
  assign bvalid_o  = (state_q == ST_WRESP);
  assign rvalid_o  = (state_q == ST_RRESP);
  assign rlast_o   = rvalid_o;   // Single beat
  assign bid_o     = id_q;
  assign rid_o     = id_q;
  assign bresp_o   = RESP_OKAY;
  assign rresp_o   = RESP_OKAY;
  assign rdata_o   = bus.rdata;  // Held by the registers until the next re

  assign aw_hs = awvalid_i && awready_o;
  assign ar_hs = arvalid_i && arready_o;

  assign bus.we    = wready_o && wvalid_i;
  assign bus.waddr = addr_q;
  assign bus.wdata = wdata_i;
  assign bus.strb  = wstrb_i;
  assign bus.re    = (state_q == ST_READ);
  assign bus.raddr = addr_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (aw_hs) begin
          state_d = ST_WDATA;
        end else if (ar_hs) begin
          state_d = ST_READ;
        end
      end
      ST_WDATA: if (wvalid_i) state_d = ST_WRESP;
      ST_WRESP: if (bready_i) state_d = ST_IDLE;
      ST_READ:  state_d = ST_RRESP;
      ST_RRESP: if (rready_i) state_d = ST_IDLE;
      default:  state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Address phase capture
  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      id_q   <= awid_i;
      addr_q <= awaddr_i[REG_ADDR_BITS-1:0];
    end else if (ar_hs) begin
      id_q   <= arid_i;
      addr_q <= araddr_i[REG_ADDR_BITS-1:0];
    end
  end

  a_awlen_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_hs |-> (awlen_i == '0));

  a_arlen_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ar_hs |-> (arlen_i == '0));

  a_we_re_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(bus.we && bus.re));

endmodule

`default_nettype wire

//--- hdl/periph_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// Register access strobes from the AXI port
interface reg_bus_if import aes_pkg::*; ();
  logic                     we;
  logic [REG_ADDR_BITS-1:0] waddr;
  logic [DATA_WIDTH-1:0]    wdata;
  logic [STRB_WIDTH-1:0]    strb;
  logic                     re;
  logic [REG_ADDR_BITS-1:0] raddr;
  logic [DATA_WIDTH-1:0]    rdata;   // Valid the cycle after re

  modport slave  (output we, waddr, wdata, strb, re, raddr, input rdata);
  modport target (input we, waddr, wdata, strb, re, raddr, output rdata);
endinterface

// Handshake between the register block and the cipher core
interface cipher_if import aes_pkg::*; ();
  logic                   start;
  logic [BLOCK_WIDTH-1:0] key;
  logic [BLOCK_WIDTH-1:0] block;
  logic                   busy;
  logic                   done;
  logic [BLOCK_WIDTH-1:0] result;

  modport ctrl (output start, key, block, input busy, done, result);
  modport core (input start, key, block, output busy, done, result);
endinterface

`default_nettype wire

//--- verification/tb_aes_periph.sv
`timescale 1ns/1ps
`default_nettype none

module tb_aes_periph;

  localparam int TIMEOUT = 100;

  logic        clk;
  logic        rst_n;
  logic [3:0]  awid;
  logic [3:0]  arid;
  logic [3:0]  bid_o;
  logic [3:0]  rid_o;
  logic [31:0] awaddr;
  logic [31:0] araddr;
  logic [31:0] wdata;
  logic [31:0] rdata_o;
  logic [7:0]  awlen;
  logic [7:0]  arlen;
  logic [2:0]  awsize;
  logic [2:0]  arsize;
  logic [1:0]  awburst;
  logic [1:0]  arburst;
  logic [1:0]  bresp_o;
  logic [1:0]  rresp_o;
  logic        awvalid;
  logic        awready_o;
  logic        wvalid;
  logic        wlast;
  logic        wready_o;
  logic        bvalid_o;
  logic        bready;
  logic        arvalid;
  logic        arready_o;
  logic        rvalid_o;
  logic        rlast_o;
  logic        rready;
  logic [3:0]  wstrb;
  logic        irq_o;
  logic        clear_irq;
  integer seed = 32'h051327c4;
  int cycle = 0;
  int hs_cycle;
  logic [31:0] rd;

  tb_clk_gen i_clk_gen (.clk_o(clk), .rst_no(rst_n));

  aes_periph i_aes_periph (
    .clk_i(clk), .rst_ni(rst_n),
    .awid_i(awid), .awaddr_i(awaddr), .awlen_i(awlen), .awsize_i(awsize),
    .awburst_i(awburst), .awvalid_i(awvalid), .awready_o(awready_o),
    .wdata_i(wdata), .wstrb_i(wstrb), .wvalid_i(wvalid), .wlast_i(wlast), .wready_o(wready_o),
    .bid_o(bid_o), .bresp_o(bresp_o), .bvalid_o(bvalid_o), .bready_i(bready),
    .arid_i(arid), .araddr_i(araddr), .arlen_i(arlen), .arsize_i(arsize),
    .arburst_i(arburst), .arvalid_i(arvalid), .arready_o(arready_o),
    .rid_o(rid_o), .rdata_o(rdata_o), .rresp_o(rresp_o), .rvalid_o(rvalid_o),
    .rlast_o(rlast_o), .rready_i(rready),
    .aes_irq_o(irq_o), .aes_clear_irq_i(clear_irq)
  );

  always @(posedge clk) cycle <= cycle + 1;

  a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid_o && !bready |=> bvalid_o && $stable(bid_o) && $stable(bresp_o))
    else begin
      $display("** Error bvalid_o/bid_o not held: bvalid_o=%h bid_o=%h", bvalid_o, bid_o);
      $display("TEST FAILED");
      $fatal;
    end

  a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid_o && !rready |=> rvalid_o && $stable(rdata_o) && $stable(rid_o) && $stable(rlast_o))
    else begin
      $display("** Error rvalid_o/rdata_o not held: rvalid_o=%h rdata_o=%h", rvalid_o, rdata_o);
      $display("TEST FAILED");
      $fatal;
    end

  // No address beat while a response is pending
  a_no_addr: assert property (@(posedge clk) disable iff (!rst_n)
    (bvalid_o || rvalid_o) |-> !awready_o && !arready_o)
    else begin
      $display("** Error awready_o=%h arready_o=%h during response", awready_o, arready_o);
      $display("TEST FAILED");
      $fatal;
    end

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("** Error %s: got 0x%08h, expected 0x%08h", name, got, exp);
      $display("TEST FAILED");
      $fatal;
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("Timeout while waiting for %s", what);
    $display("TEST FAILED");
    $fatal;
  endtask

  task automatic axi_write(input logic [3:0] id, input logic [31:0] addr,
                           input logic [31:0] data, input logic [3:0] strb, input bit rand_b);
    int n;
    int gap;
    awid = id;
    awaddr = addr;
    awvalid = 1'b1;
    n = 0;
    while (!awready_o) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) timeout_fail("AW handshake");
    end
    @(negedge clk);
    awvalid = 1'b0;
    wdata = data;
    wstrb = strb;
    wvalid = 1'b1;
    wlast = 1'b1;
    n = 0;
    while (!wready_o) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) timeout_fail("W handshake");
    end
    hs_cycle = cycle + 1;   // Edge that takes the W beat
    @(negedge clk);
    wvalid = 1'b0;
    wlast = 1'b0;
    gap = rand_b ? $unsigned($random(seed)) % 5 : 0;
    repeat (gap) @(negedge clk);
    bready = 1'b1;
    n = 0;
    while (!bvalid_o) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) timeout_fail("B response");
    end
    check_val("bid_o", 32'(bid_o), 32'(id));
    check_val("bresp_o", 32'(bresp_o), 32'h0);
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [3:0] id, input logic [31:0] addr,
                          output logic [31:0] data);
    int n;
    int gap;
    arid = id;
    araddr = addr;
    arvalid = 1'b1;
    n = 0;
    while (!arready_o) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) timeout_fail("AR handshake");
    end
    @(negedge clk);
    arvalid = 1'b0;
    gap = $unsigned($random(seed)) % 5;
    repeat (gap) @(negedge clk);
    rready = 1'b1;
    n = 0;
    while (!rvalid_o) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) timeout_fail("R response");
    end
    data = rdata_o;
    check_val("rid_o", 32'(rid_o), 32'(id));
    check_val("rresp_o", 32'(rresp_o), 32'h0);
    check_val("rlast_o", 32'(rlast_o), 32'h1);
    @(negedge clk);
    rready = 1'b0;
  endtask

  task automatic wait_irq();
    int n;
    n = 0;
    while (!irq_o) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) timeout_fail("aes_irq_o");
    end
  endtask

  task automatic load_block(input logic [127:0] key, input logic [127:0] pt);
    for (int i = 0; i < 4; i++) begin
      axi_write(4'(i), 32'h10 + 4 * i, key[127 - 32 * i -: 32], 4'hf, 1'b1);
      axi_write(4'(i + 4), 32'h20 + 4 * i, pt[127 - 32 * i -: 32], 4'hf, 1'b1);
    end
  endtask

  task automatic check_dout(input logic [127:0] ct);
    logic [31:0] d;
    for (int i = 0; i < 4; i++) begin
      axi_read(4'(9 + i), 32'h30 + 4 * i, d);
      check_val("rdata_o DOUT", d, ct[127 - 32 * i -: 32]);
    end
  endtask

  initial begin
    int n;
    awid = '0;
    awaddr = '0;
    awlen = '0;
    awsize = 3'd2;
    awburst = 2'b01;
    awvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    wvalid = 1'b0;
    wlast = 1'b0;
    bready = 1'b0;
    arid = '0;
    araddr = '0;
    arlen = '0;
    arsize = 3'd2;
    arburst = 2'b01;
    arvalid = 1'b0;
    rready = 1'b0;
    clear_irq = 1'b0;
    n = 0;
    while (rst_n !== 1'b1) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) timeout_fail("reset release");
    end
    check_val("awready_o", 32'(awready_o), 32'h1);
    check_val("arready_o", 32'(arready_o), 32'h1);
    check_val("wready_o", 32'(wready_o), 32'h0);
    check_val("bvalid_o", 32'(bvalid_o), 32'h0);
    check_val("rvalid_o", 32'(rvalid_o), 32'h0);
    check_val("aes_irq_o", 32'(irq_o), 32'h0);
    axi_read(4'h3, 32'h04, rd);
    check_val("rdata_o STATUS", rd, 32'h0);

    // Register round trip, partial strobes and read-only DOUT
    axi_write(4'ha, 32'h14, 32'hdeadbeef, 4'hf, 1'b1);
    axi_read(4'hb, 32'h14, rd);
    check_val("rdata_o KEY[1]", rd, 32'hdeadbeef);
    axi_write(4'hc, 32'h14, 32'h11223344, 4'b0101, 1'b1);
    axi_read(4'hd, 32'h14, rd);
    check_val("rdata_o KEY[1]", rd, 32'hde22be44);
    axi_write(4'he, 32'h28, 32'hcafef00d, 4'hf, 1'b1);
    axi_read(4'hf, 32'h28, rd);
    check_val("rdata_o DIN[2]", rd, 32'hcafef00d);
    axi_write(4'h5, 32'h30, 32'hffffffff, 4'hf, 1'b1);
    axi_read(4'h6, 32'h30, rd);
    check_val("rdata_o DOUT[0]", rd, 32'h0);

    // FIPS-197 C.1
    load_block(128'h000102030405060708090a0b0c0d0e0f, 128'h00112233445566778899aabbccddeeff);
    axi_write(4'h1, 32'h00, 32'h1, 4'hf, 1'b0);
    wait_irq();
    check_val("aes_irq_o delay", 32'(cycle - hs_cycle), 32'd12);
    check_dout(128'h69c4e0d86a7b0430d8cdb78070b4c55a);
    axi_read(4'h2, 32'h04, rd);
    check_val("rdata_o STATUS", rd, 32'h2);

    // Interrupt clear
    clear_irq = 1'b1;
    @(negedge clk);
    clear_irq = 1'b0;
    check_val("aes_irq_o", 32'(irq_o), 32'h0);

    // FIPS-197 Appendix B
    load_block(128'h2b7e151628aed2a6abf7158809cf4f3c, 128'h3243f6a8885a308d313198a2e0370734);
    axi_write(4'h1, 32'h00, 32'h1, 4'hf, 1'b0);
    wait_irq();
    check_dout(128'h3925841d02dc09fbdc118597196a0b32);
    clear_irq = 1'b1;
    @(negedge clk);
    clear_irq = 1'b0;

    // Second start while busy must be ignored
    axi_write(4'h1, 32'h00, 32'h1, 4'hf, 1'b0);
    axi_write(4'h7, 32'h20, 32'h0, 4'hf, 1'b0);
    axi_write(4'h8, 32'h00, 32'h1, 4'hf, 1'b0);
    wait_irq();
    check_dout(128'h3925841d02dc09fbdc118597196a0b32);

    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;   // 8 ns period
  end

  // Reset held for 8 cycles, released on a falling edge
  initial begin
    rst_no = 1'b0;
    repeat (8) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

//--- verilog.f
hdl/aes_pkg.sv
hdl/periph_ifs.sv
hdl/axi_slave_port.sv
hdl/aes_regs.sv
hdl/aes_cipher.sv
hdl/aes_periph.sv
verification/tb_clk_gen.sv
verification/tb_aes_periph.sv
